// ==== bench/tag_rx_tb.sv ====
`timescale 1ns/10ps

module tag_rx_tb;

  import tag_rx_pkg::*;

  typedef enum {watch_trig, watch_mux, watch_stb, watch_idle} watch_e;
  typedef enum {stim_zero, stim_const, stim_rand} stim_e;

  logic                   clk;
  logic                   rst;
  logic                   run_rx;
  iq_t                    rx_in;
  logic [data_width-1:0]  scale_val;
  iq_t                    rx_out;
  logic                   rx_valid;
  logic                   rx_trig;
  logic                   rx_out_mux;
  logic                   peak_detect_stb;
  logic [data_width-1:0]  pow_mag;
  rx_state_e              rx_state;
  logic [nsync_width-1:0] nsync_count;
  logic [phase_width-1:0] ph;
  logic [symb_width-1:0]  symb_n;

  stim_e                 stim_mode;
  iq_t                   const_in;
  logic [data_width-1:0] exp_scale;
  logic                  chk_en;
  iq_t                   in_d1;
  iq_t                   in_d2;
  int                    since_trig = 0;

  tag_rx_top dut_i (
    .clk, .rst, .run_rx, .rx_in, .scale_val, .rx_out, .rx_valid, .rx_trig,
    .rx_out_mux, .peak_detect_stb, .pow_mag, .rx_state, .nsync_count, .ph, .symb_n
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_iq(input string name, input iq_t exp, input iq_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected i=%0d q=%0d, actual i=%0d q=%0d",
               name, exp.i, exp.q, act.i, act.q);
      stop_run();
    end
  endtask

  task automatic check_state(input string name, input rx_state_e exp, input rx_state_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  function automatic longint sat_sample(input longint v);
    if (v > sample_max) begin
      return sample_max;
    end
    if (v < sample_min) begin
      return sample_min;
    end
    return v;
  endfunction

  // Symbols counted k cycles after the demodulator leaves reset.
  function automatic int symbols_done(input int k);
    if (k / symb_len < nsymb) begin
      return k / symb_len;
    end
    return nsymb;
  endfunction

  // Sync value when sync_idx >= 0, else the scaled input rotated by n steps.
  function automatic iq_t ref_rx(input iq_t x, input logic [data_width-1:0] sv,
                                 input int n, input int sync_idx);
    longint s;
    longint a;
    longint b;
    int     quad;
    iq_t    r;
    if (sync_idx >= 0) begin
      r.i = (sync_idx < nsyncp) ? data_width'(full_scale) : data_width'(-full_scale);
      r.q = '0;
      return r;
    end
    s = (sv == '0) ? 1 : longint'(sv);   // Zero scale means unity.
    a = sat_sample((longint'(x.i) * s) >>> scale_shift);
    b = sat_sample((longint'(x.q) * s) >>> scale_shift);
    quad = ((n * ph_inc) % (2 ** phase_width)) / (2 ** (phase_width - 2));
    case (quad)
      0: begin
        r.i = data_width'(a);
        r.q = data_width'(b);
      end
      1: begin
        r.i = data_width'(b);
        r.q = data_width'(sat_sample(-a));
      end
      2: begin
        r.i = data_width'(sat_sample(-a));
        r.q = data_width'(sat_sample(-b));
      end
      default: begin
        r.i = data_width'(sat_sample(-b));
        r.q = data_width'(a);
      end
    endcase
    return r;
  endfunction

  function automatic logic probe(input watch_e sel);
    case (sel)
      watch_trig: return rx_trig;
      watch_mux:  return rx_out_mux;
      watch_stb:  return peak_detect_stb;
      default:    return (rx_state == init);
    endcase
  endfunction

  task automatic wait_until(input watch_e sel, input logic level, input int limit,
                            input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level && n < limit) begin
      n++;
      @(negedge clk);
    end
    if (probe(sel) !== level) begin
      $display("Timed out after %0d cycles waiting for %s.", limit, what);
      stop_run();
    end
  endtask

  initial begin : stimulus
    void'($urandom(11439));
    forever begin
      @(posedge clk);
      case (stim_mode)
        stim_zero:  rx_in <= '0;
        stim_const: rx_in <= const_in;
        default: begin
          rx_in.i <= data_width'($urandom);
          rx_in.q <= data_width'($urandom);
        end
      endcase
    end
  end

  // Demodulated output lags the input by two cycles and counts phase from the end of rx_trig.
  always @(negedge clk) begin
    if (rx_trig === 1'b1) begin
      since_trig = -1;
    end else begin
      since_trig = since_trig + 1;
    end
    if (chk_en && since_trig >= 2) begin
      check_iq("demod", ref_rx(in_d2, exp_scale, since_trig - 1, -1), rx_out);
      check_word("demod ph", data_width'((since_trig * ph_inc) % (2 ** phase_width)),
                 data_width'(ph));
      check_word("demod symb_n", data_width'(symbols_done(since_trig)),
                 data_width'(symb_n));
    end
    in_d2 = in_d1;
    in_d1 = rx_in;
  end

  initial begin : scenario
    int  trig_cnt;
    iq_t exp_det;
    rst        = 1'b1;
    run_rx     = 1'b1;
    rx_in      = '0;
    scale_val  = data_width'(16);
    exp_scale  = data_width'(16);
    const_in.i = 16'sd1000;
    const_in.q = '0;
    stim_mode  = stim_zero;
    chk_en     = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    repeat (20 * dec_rate) begin
      @(negedge clk);
      check_bit("quiet rx_trig", 1'b0, rx_trig);
      check_bit("quiet rx_valid", 1'b0, rx_valid);
      check_bit("quiet rx_out_mux", 1'b0, rx_out_mux);
      check_bit("quiet peak_detect_stb", 1'b0, peak_detect_stb);
      check_state("quiet rx_state", init, rx_state);
      check_iq("quiet rx_out", ref_rx('0, exp_scale, 0, -1), rx_out);
    end

    stim_mode = stim_const;
    exp_det = ref_rx(const_in, exp_scale, 0, -1);
    wait_until(watch_stb, 1'b1, 100, "peak_detect_stb");
    check_word("detect pow_mag", exp_det.i, pow_mag);   // Mean of |i| + |q|.

    wait_until(watch_mux, 1'b1, 20, "rx_out_mux");
    trig_cnt = 0;
    for (int n = 0; n < nsync_total; n++) begin
      if (n > 0) begin
        @(negedge clk);
      end
      check_iq("sync rx_out", ref_rx('0, exp_scale, 0, n), rx_out);
      check_bit("sync rx_out_mux", 1'b1, rx_out_mux);
      check_bit("sync rx_trig", (n < nsync_total - 1), rx_trig);
      check_bit("sync rx_valid", 1'b1, rx_valid);
      check_word("sync nsync_count",
                 data_width'((n < nsync_total - 1) ? n + 1 : nsync_total - 1),
                 data_width'(nsync_count));
      if (rx_trig) begin
        trig_cnt++;
      end
    end
    check_word("sync rx_trig length", data_width'(nsync_total - 1), data_width'(trig_cnt));
    check_state("sync end rx_state", loc_rx, rx_state);

    chk_en = 1'b1;
    stim_mode = stim_rand;
    @(negedge clk);
    check_bit("sync end rx_out_mux", 1'b0, rx_out_mux);
    wait_until(watch_idle, 1'b1, 120, "return to init");
    chk_en = 1'b0;

    @(posedge clk);
    scale_val <= '0;
    exp_scale = '0;
    wait_until(watch_trig, 1'b1, 100, "rx_trig with zero scale");
    wait_until(watch_trig, 1'b0, 100, "end of rx_trig with zero scale");
    chk_en = 1'b1;
    repeat (24) @(negedge clk);
    wait_until(watch_trig, 1'b1, 150, "next resync");
    chk_en = 1'b0;

    @(posedge clk);
    run_rx <= 1'b0;
    @(negedge clk);
    check_bit("run_rx low, trig still set", 1'b1, rx_trig);
    repeat (2 * dec_rate) begin
      @(negedge clk);
      check_bit("run_rx low rx_trig", 1'b0, rx_trig);
      check_state("run_rx low rx_state", init, rx_state);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== logic/iq_scaler.sv ====
`timescale 1ns/10ps

module iq_scaler (
  input  logic                              clk,
  input  logic                              rst,
  input  tag_rx_pkg::iq_t                   rx_in,
  input  logic [tag_rx_pkg::data_width-1:0] scale,
  output tag_rx_pkg::iq_t                   scaled
);

  import tag_rx_pkg::*;

  iq_t scaled_next;

  // Scale is unsigned, so it gets a zero sign bit before the multiply.
  function automatic logic signed [data_width-1:0] scale_one(
    input logic signed [data_width-1:0] x,
    input logic        [data_width-1:0] s
  );
    logic signed [2*data_width:0] prod;
    prod = (x * $signed({1'b0, s})) >>> scale_shift;
    if (prod > sample_max) begin
      return data_width'(sample_max);
    end
    if (prod < sample_min) begin
      return data_width'(sample_min);
    end
    return prod[data_width-1:0];
  endfunction

  always_comb begin
    scaled_next.i = scale_one(rx_in.i, scale);
    scaled_next.q = scale_one(rx_in.q, scale);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scaled <= '0;           // Keeps the first detector window clean.
    end else begin
      scaled <= scaled_next;
    end
  end

  // The controller replaces a zero scale value with one.
  scale_nonzero_a : assert property (
    @(posedge clk) disable iff (rst)
    scale != '0
  );

endmodule

// ==== logic/preamble_detect.sv ====
`timescale 1ns/10ps

module preamble_detect (
  input  logic              clk,
  input  logic              rst,
  input  tag_rx_pkg::iq_t   scaled,
  output tag_rx_pkg::peak_t peak
);

  import tag_rx_pkg::*;

  logic [win_width-1:0]  win_cnt;
  logic [acc_width-1:0]  acc;
  logic [acc_width-1:0]  window_sum;
  logic [acc_width-1:0]  mean_full;
  logic [data_width-1:0] mean;
  logic [data_width+1:0] mag;
  logic [run_width-1:0]  run_cnt;
  logic [run_width-1:0]  run_next;
  logic                  above;
  logic                  last_sample;
  logic                  tvalid;
  logic                  stb;
  logic [data_width-1:0] pow_mag;

  function automatic logic [data_width:0] abs_val(
    input logic signed [data_width-1:0] x
  );
    logic signed [data_width:0] ext;
    ext = x;
    return (ext < 0) ? -ext : ext;
  endfunction

  assign last_sample = (win_cnt == win_width'(dec_rate - 1));

  always_comb begin
    mag        = abs_val(scaled.i) + abs_val(scaled.q);
    window_sum = acc + acc_width'(mag);
    mean_full  = window_sum >> win_width;   // Divide by dec_rate.
    if (|mean_full[acc_width-1:data_width]) begin
      mean = '1;
    end else begin
      mean = mean_full[data_width-1:0];
    end
    above = (mean > noise_pow);
    if (!above) begin
      run_next = '0;
    end else if (run_cnt == run_width'(nrx_trig)) begin
      run_next = run_cnt;                   // Hold at the trigger count.
    end else begin
      run_next = run_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      win_cnt <= '0;
      acc     <= '0;
      run_cnt <= '0;
      tvalid  <= 1'b0;
      stb     <= 1'b0;
    end else begin
      tvalid <= 1'b0;
      stb    <= 1'b0;
      if (last_sample) begin
        win_cnt <= '0;
        acc     <= '0;
        run_cnt <= run_next;
        tvalid  <= 1'b1;
        stb     <= (run_next >= run_width'(nrx_trig));
      end else begin
        win_cnt <= win_cnt + 1'b1;
        acc     <= window_sum;
      end
    end
  end

  // Window mean is held until the next window closes.
  always_ff @(posedge clk) begin
    if (last_sample) begin
      pow_mag <= mean;
    end
  end

  always_comb begin
    peak.tvalid  = tvalid;
    peak.stb     = stb;
    peak.pow_mag = pow_mag;
  end

  tvalid_single_a : assert property (
    @(posedge clk) disable iff (rst)
    peak.tvalid |=> !peak.tvalid [*(dec_rate - 1)] ##1 peak.tvalid
  );

endmodule

// ==== logic/tag_demod.sv ====
`timescale 1ns/10ps

module tag_demod (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               srst,
  input  tag_rx_pkg::iq_t                    scaled,
  output tag_rx_pkg::iq_t                    bb,
  output logic                               sync_ready,
  output logic [tag_rx_pkg::phase_width-1:0] ph,
  output logic [tag_rx_pkg::symb_width-1:0]  symb_n
);

  import tag_rx_pkg::*;

  logic [phase_width-1:0] phase;
  logic [1:0]             quad;
  logic [samp_width-1:0]  samp_cnt;
  logic [symb_width-1:0]  symb_cnt;

  // Negating the most negative sample would wrap.
  function automatic logic signed [data_width-1:0] neg_sat(
    input logic signed [data_width-1:0] x
  );
    if (x == data_width'(sample_min)) begin
      return data_width'(sample_max);
    end
    return -x;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || srst) begin
      phase <= '0;
    end else begin
      phase <= phase + phase_width'(ph_inc);
    end
  end

  assign quad = phase[phase_width-1 -: 2];   // Current quadrant.

  always_comb begin
    case (quad)
      2'd0: begin
        bb.i = scaled.i;
        bb.q = scaled.q;
      end
      2'd1: begin
        bb.i = scaled.q;
        bb.q = neg_sat(scaled.i);
      end
      2'd2: begin
        bb.i = neg_sat(scaled.i);
        bb.q = neg_sat(scaled.q);
      end
      default: begin
        bb.i = neg_sat(scaled.q);
        bb.q = scaled.i;
      end
    endcase
  end

  // Counts one frame of symbols and then flags the controller.
  always_ff @(posedge clk) begin
    if (rst || srst) begin
      samp_cnt   <= '0;
      symb_cnt   <= '0;
      sync_ready <= 1'b0;
    end else if (!sync_ready) begin
      samp_cnt <= samp_cnt + 1'b1;
      if (samp_cnt == samp_width'(symb_len - 1)) begin
        symb_cnt <= symb_cnt + 1'b1;
        if (symb_cnt == symb_width'(nsymb - 1)) begin
          sync_ready <= 1'b1;
        end
      end
    end
  end

  assign ph     = phase;
  assign symb_n = symb_cnt;

  srst_clears_ready_a : assert property (
    @(posedge clk) disable iff (rst)
    srst |=> !sync_ready [*(nsymb * symb_len)]
  );

endmodule

// ==== logic/tag_rx_ctrl.sv ====
`timescale 1ns/10ps

module tag_rx_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               run_rx,
  input  tag_rx_pkg::peak_t                  peak,
  input  tag_rx_pkg::iq_t                    bb,
  input  logic                               sync_ready,
  input  logic [tag_rx_pkg::data_width-1:0]  scale_val,
  output logic [tag_rx_pkg::data_width-1:0]  scale,
  output logic                               rx_trig,
  output logic                               rx_valid,
  output logic                               rx_out_mux,
  output tag_rx_pkg::iq_t                    rx_out,
  output tag_rx_pkg::rx_state_e              rx_state,
  output logic [tag_rx_pkg::nsync_width-1:0] nsync_count
);

  import tag_rx_pkg::*;

  rx_state_e              state;
  logic [nsync_width-1:0] ncount;
  logic                   sync_pos;
  iq_t                    sel_out;

  always_ff @(posedge clk) begin
    if (rst || !run_rx) begin
      state    <= init;
      ncount   <= '0;
      rx_trig  <= 1'b0;
      rx_valid <= 1'b0;
      scale    <= data_width'(1);
    end else begin
      case (state)
        init: begin
          scale <= (scale_val == '0) ? data_width'(1) : scale_val;
          if (peak.tvalid) begin
            if (peak.stb) begin
              state    <= loc_sync;
              ncount   <= '0;
              rx_valid <= 1'b1;
            end else begin
              rx_valid <= 1'b0;      // Drop valid on a quiet window.
            end
          end
        end
        loc_sync: begin
          if (ncount < nsync_width'(nsync_total - 1)) begin
            ncount  <= ncount + 1'b1;
            rx_trig <= 1'b1;         // Demodulator held in reset.
          end else begin
            rx_trig <= 1'b0;
            state   <= loc_rx;
          end
        end
        loc_rx: begin
          if (sync_ready && peak.tvalid) begin
            state <= init;
          end
        end
        default: begin
          state <= init;
        end
      endcase
    end
  end

  // The sync pattern is positive first and negative after.
  assign sync_pos = (ncount < nsync_width'(nsyncp));

  always_comb begin
    if (state == loc_sync) begin
      sel_out.i = sync_pos ? data_width'(full_scale) : data_width'(-full_scale);
      sel_out.q = '0;
    end else begin
      sel_out = bb;
    end
  end

  always_ff @(posedge clk) begin
    rx_out <= sel_out;
  end

  // Flags the sync pattern in step with rx_out.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_out_mux <= 1'b0;
    end else begin
      rx_out_mux <= (state == loc_sync);
    end
  end

  assign rx_state    = state;
  assign nsync_count = ncount;

  trig_in_sync_a : assert property (
    @(posedge clk) disable iff (rst)
    rx_trig |-> (state == loc_sync) || (state == loc_rx && $past(state) == loc_sync)
  );

endmodule

// ==== logic/tag_rx_pkg.sv ====
package tag_rx_pkg;

  // Sample and phase widths.
  localparam int data_width  = 16;
  localparam int phase_width = 12;
  localparam int ph_inc      = 256;   // Quarter turn every 4 samples.
  localparam int scale_shift = 4;

  // Sync pattern.
  localparam int full_scale = 16384;
  localparam int nsyncp     = 16;
  localparam int nsyncn     = 16;

  // Preamble detection.
  localparam int dec_rate       = 8;
  localparam int nrx_trig       = 4;
  localparam int nrx_trig_delay = (nrx_trig - 1) * dec_rate;
  localparam int nsync_total    = nsyncp + nsyncn + nrx_trig_delay;
  localparam int noise_pow      = 200;

  // Symbol framing.
  localparam int symb_len = 8;
  localparam int nsymb    = 4;

  // Derived counter widths.
  localparam int nsync_width = $clog2(nsync_total);
  localparam int win_width   = $clog2(dec_rate);
  localparam int acc_width   = data_width + win_width + 2;
  localparam int run_width   = $clog2(nrx_trig + 1);
  localparam int samp_width  = $clog2(symb_len);
  localparam int symb_width  = $clog2(nsymb + 1);

  // Signed sample limits for saturation.
  localparam int sample_max = 2 ** (data_width - 1) - 1;
  localparam int sample_min = -(2 ** (data_width - 1));

  typedef struct packed {
    logic signed [data_width-1:0] i;
    logic signed [data_width-1:0] q;
  } iq_t;

  // One window result from the preamble detector.
  typedef struct packed {
    logic                  tvalid;
    logic                  stb;
    logic [data_width-1:0] pow_mag;
  } peak_t;

  typedef enum logic [1:0] {
    init     = 2'b00,
    loc_sync = 2'b01,
    loc_rx   = 2'b11
  } rx_state_e;

endpackage

// ==== logic/tag_rx_top.sv ====
`timescale 1ns/10ps

module tag_rx_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               run_rx,
  input  tag_rx_pkg::iq_t                    rx_in,
  input  logic [tag_rx_pkg::data_width-1:0]  scale_val,
  output tag_rx_pkg::iq_t                    rx_out,
  output logic                               rx_valid,
  output logic                               rx_trig,
  output logic                               rx_out_mux,
  output logic                               peak_detect_stb,
  output logic [tag_rx_pkg::data_width-1:0]  pow_mag,
  output tag_rx_pkg::rx_state_e              rx_state,
  output logic [tag_rx_pkg::nsync_width-1:0] nsync_count,
  output logic [tag_rx_pkg::phase_width-1:0] ph,
  output logic [tag_rx_pkg::symb_width-1:0]  symb_n
);

  import tag_rx_pkg::*;

  iq_t                   scaled;
  iq_t                   bb;
  peak_t                 peak;
  logic [data_width-1:0] scale;
  logic                  sync_ready;

  iq_scaler scaler_i (
    .clk, .rst, .rx_in, .scale, .scaled
  );

  preamble_detect detect_i (
    .clk, .rst, .scaled, .peak
  );

  tag_demod demod_i (
    .clk, .rst, .srst(rx_trig), .scaled, .bb, .sync_ready, .ph, .symb_n
  );

  tag_rx_ctrl ctrl_i (
    .clk, .rst, .run_rx, .peak, .bb, .sync_ready, .scale_val, .scale,
    .rx_trig, .rx_valid, .rx_out_mux, .rx_out, .rx_state, .nsync_count
  );

  assign peak_detect_stb = peak.stb;
  assign pow_mag         = peak.pow_mag;

endmodule

// ==== tb.f ====
logic/tag_rx_pkg.sv
logic/iq_scaler.sv
logic/preamble_detect.sv
logic/tag_demod.sv
logic/tag_rx_ctrl.sv
logic/tag_rx_top.sv
bench/tag_rx_tb.sv
